// ==== source/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Vectored mtvec mode, 1 enables BASE + 4*cause for interrupts
`define CSR_VECTORED_EN 1'b1

// Reset value of the mtvec BASE field, word address
`define CSR_MTVEC_BASE_INIT 30'd0

// mcause after reset, interrupt bit 0 and code 16
`define CSR_MCAUSE_INIT 32'h0000_0010

// misa with MXL 1 (RV32), extensions I (bit 8) and M (bit 12)
`define CSR_MISA_VAL 32'h4000_1100

// Non-commercial implementation, bank and offset zero
`define CSR_MVENDORID_VAL 32'h0000_0000

// Architecture not registered
`define CSR_MARCHID_VAL 32'h0000_0000

// Implementation version "1.00" in ASCII
`define CSR_MIMPID_VAL 32'h312E_3030

// Single hart system
`define CSR_MHARTID_VAL 32'h0000_0000

`endif

// ==== source/csr_addr_pkg.sv ====
package csr_addr_pkg;

	typedef logic [11:0] csr_addr_t;

	// Machine information registers
	localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
	localparam csr_addr_t ADDR_MARCHID = 12'hF12;
	localparam csr_addr_t ADDR_MIMPID = 12'hF13;
	localparam csr_addr_t ADDR_MHARTID = 12'hF14;

	// Machine trap setup
	localparam csr_addr_t ADDR_MSTATUS = 12'h300;
	localparam csr_addr_t ADDR_MISA = 12'h301;
	localparam csr_addr_t ADDR_MIE = 12'h304;
	localparam csr_addr_t ADDR_MTVEC = 12'h305;

	// Machine trap handling
	localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
	localparam csr_addr_t ADDR_MEPC = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE = 12'h342;
	localparam csr_addr_t ADDR_MTVAL = 12'h343;
	localparam csr_addr_t ADDR_MIP = 12'h344;

	typedef enum logic [1:0] {
		UPD_LOAD = 2'b00, // Replace with mask value
		UPD_SET = 2'b01, // OR mask into old value
		UPD_CLR = 2'b10 // Clear bits set in mask
	} upd_type_e;

	// One strobe per writable register
	typedef struct packed {
		logic mstatus;
		logic mie;
		logic mtvec;
		logic mscratch;
		logic mepc;
		logic mcause;
		logic mtval;
	} csr_wr_sel_t;

endpackage

// ==== source/csr_field_pkg.sv ====
package csr_field_pkg;

	localparam int ITR_CAUSE_W = 8; // Trap cause input width

	typedef logic [31:0] csr_word_t;

	typedef struct packed {
		logic [18:0] rsv_31_13;
		logic [1:0] mpp; // Always machine mode
		logic [2:0] rsv_10_8;
		logic mpie;
		logic [2:0] rsv_6_4;
		logic mie;
		logic [2:0] rsv_2_0;
	} mstatus_view_t;

	// Shared by mie and mip
	typedef struct packed {
		logic [19:0] rsv_31_12;
		logic me; // External
		logic [2:0] rsv_10_8;
		logic mt; // Timer
		logic [2:0] rsv_6_4;
		logic ms; // Software
		logic [2:0] rsv_2_0;
	} irq_view_t;

	typedef struct packed {
		logic [29:0] base; // Word aligned base
		logic [1:0] mode; // 0 direct, 1 vectored
	} mtvec_view_t;

	typedef struct packed {
		logic intr;
		logic [30:0] code;
	} mcause_view_t;

	// One write word, read through the layout of the target register
	typedef union packed {
		csr_word_t raw;
		mstatus_view_t mstatus;
		irq_view_t irq;
		mtvec_view_t mtvec;
		mcause_view_t mcause;
	} csr_word_u;

endpackage

// ==== source/csr_access_port.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_access_port (
	input logic clk,
	input logic resetn,
	input logic csr_valid,
	input csr_addr_pkg::csr_addr_t csr_addr,
	input csr_addr_pkg::upd_type_e csr_upd_type,
	input csr_field_pkg::csr_word_t csr_mask_v,
	input csr_field_pkg::csr_word_t mstatus_q,
	input csr_field_pkg::csr_word_t mtvec_q,
	input csr_field_pkg::csr_word_t mepc_q,
	input csr_field_pkg::csr_word_t mcause_q,
	input csr_field_pkg::csr_word_t mtval_q,
	input csr_field_pkg::csr_word_t mscratch_q,
	input csr_field_pkg::csr_word_t mie_q,
	input csr_field_pkg::csr_word_t mip_q,
	output csr_field_pkg::csr_word_t csr_dout,
	output csr_field_pkg::csr_word_u wr_data,
	output csr_addr_pkg::csr_wr_sel_t wr_sel
);

	csr_field_pkg::csr_word_t rd_word; // Old value of addressed CSR
	csr_addr_pkg::csr_wr_sel_t hit_sel; // Writable target, before valid

	// Single decode feeds both the read mux and the write strobes
	always_comb
	begin
		rd_word = '0;
		hit_sel = '0;
		case (csr_addr)
			csr_addr_pkg::ADDR_MSTATUS:
			begin
				rd_word = mstatus_q;
				hit_sel.mstatus = 1'b1;
			end
			csr_addr_pkg::ADDR_MIE:
			begin
				rd_word = mie_q;
				hit_sel.mie = 1'b1;
			end
			csr_addr_pkg::ADDR_MTVEC:
			begin
				rd_word = mtvec_q;
				hit_sel.mtvec = 1'b1;
			end
			csr_addr_pkg::ADDR_MSCRATCH:
			begin
				rd_word = mscratch_q;
				hit_sel.mscratch = 1'b1;
			end
			csr_addr_pkg::ADDR_MEPC:
			begin
				rd_word = mepc_q;
				hit_sel.mepc = 1'b1;
			end
			csr_addr_pkg::ADDR_MCAUSE:
			begin
				rd_word = mcause_q;
				hit_sel.mcause = 1'b1;
			end
			csr_addr_pkg::ADDR_MTVAL:
			begin
				rd_word = mtval_q;
				hit_sel.mtval = 1'b1;
			end
			csr_addr_pkg::ADDR_MIP: rd_word = mip_q; // Read only, follows request pins
			csr_addr_pkg::ADDR_MISA: rd_word = `CSR_MISA_VAL;
			csr_addr_pkg::ADDR_MVENDORID: rd_word = `CSR_MVENDORID_VAL;
			csr_addr_pkg::ADDR_MARCHID: rd_word = `CSR_MARCHID_VAL;
			csr_addr_pkg::ADDR_MIMPID: rd_word = `CSR_MIMPID_VAL;
			csr_addr_pkg::ADDR_MHARTID: rd_word = `CSR_MHARTID_VAL;
			default: rd_word = '0; // Unmapped reads zero
		endcase
	end

	assign csr_dout = rd_word;

	// Atomic read-modify-write word
	always_comb
	begin
		case (csr_upd_type)
			csr_addr_pkg::UPD_LOAD: wr_data.raw = csr_mask_v;
			csr_addr_pkg::UPD_SET: wr_data.raw = rd_word | csr_mask_v;
			csr_addr_pkg::UPD_CLR: wr_data.raw = rd_word & ~csr_mask_v;
			default: wr_data.raw = rd_word; // Reserved type keeps old value
		endcase
	end

	assign wr_sel = csr_valid ? hit_sel : '0;

endmodule

// ==== source/csr_trap_regs.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap_regs (
	input logic clk,
	input logic resetn,
	input csr_field_pkg::csr_word_u wr_data,
	input csr_addr_pkg::csr_wr_sel_t wr_sel,
	input logic trap_enter,
	input logic trap_is_intr,
	input logic [csr_field_pkg::ITR_CAUSE_W-1:0] trap_cause,
	input csr_field_pkg::csr_word_t trap_ret_addr,
	input csr_field_pkg::csr_word_t trap_val,
	input logic trap_ret,
	output csr_field_pkg::csr_word_t mstatus_q,
	output csr_field_pkg::csr_word_t mtvec_q,
	output csr_field_pkg::csr_word_t mepc_q,
	output csr_field_pkg::csr_word_t mcause_q,
	output csr_field_pkg::csr_word_t mtval_q,
	output csr_field_pkg::csr_word_t mscratch_q,
	output logic mstatus_mie,
	output csr_field_pkg::csr_word_t trap_vec_addr,
	output csr_field_pkg::csr_word_t mepc_ret_addr
);

	localparam logic [1:0] MODE_VECTORED = 2'b01;

	logic mie_r;
	logic mpie_r;
	csr_field_pkg::mstatus_view_t mstatus_v;
	csr_field_pkg::mtvec_view_t mtvec_r;
	csr_field_pkg::mcause_view_t mcause_r;
	csr_field_pkg::csr_word_t mepc_r;
	csr_field_pkg::csr_word_t mtval_r;
	csr_field_pkg::csr_word_t mscratch_r;
	logic vec_on;
	csr_field_pkg::csr_word_t vec_off; // 4*cause, or zero when direct

	// Trap events override a software write in the same cycle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mie_r <= 1'b0;
			mpie_r <= 1'b1;
		end
		else if (trap_enter)
		begin
			mie_r <= 1'b0;
			mpie_r <= mie_r; // Save current enable
		end
		else if (trap_ret)
		begin
			mie_r <= mpie_r;
			mpie_r <= 1'b1;
		end
		else if (wr_sel.mstatus)
		begin
			mie_r <= wr_data.mstatus.mie;
			mpie_r <= wr_data.mstatus.mpie;
		end
	end

	always_comb
	begin
		mstatus_v = '0;
		mstatus_v.mpp = 2'b11;
		mstatus_v.mpie = mpie_r;
		mstatus_v.mie = mie_r;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mtvec_r.base <= `CSR_MTVEC_BASE_INIT;
			mtvec_r.mode <= 2'b00;
		end
		else if (wr_sel.mtvec)
			mtvec_r <= wr_data.mtvec;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mcause_r <= `CSR_MCAUSE_INIT;
		else if (trap_enter)
		begin
			mcause_r.intr <= trap_is_intr;
			mcause_r.code <= {{(31 - csr_field_pkg::ITR_CAUSE_W){1'b0}}, trap_cause};
		end
		else if (wr_sel.mcause)
			mcause_r <= wr_data.mcause;
	end

	// Payload registers
	always_ff @(posedge clk)
	begin
		if (trap_enter)
		begin
			mepc_r <= trap_ret_addr;
			mtval_r <= trap_val;
		end
		else
		begin
			if (wr_sel.mepc)
				mepc_r <= wr_data.raw;
			if (wr_sel.mtval)
				mtval_r <= wr_data.raw;
		end
		if (wr_sel.mscratch)
			mscratch_r <= wr_data.raw;
	end

	// Vectored jump only for interrupts
	assign vec_on = (`CSR_VECTORED_EN != 1'b0) && (mtvec_r.mode == MODE_VECTORED) && trap_is_intr;
	assign vec_off = vec_on ?
		{{(30 - csr_field_pkg::ITR_CAUSE_W){1'b0}}, trap_cause, 2'b00} : '0;
	assign trap_vec_addr = {mtvec_r.base, 2'b00} + vec_off;

	assign mstatus_q = mstatus_v;
	assign mtvec_q = mtvec_r;
	assign mepc_q = mepc_r;
	assign mcause_q = mcause_r;
	assign mtval_q = mtval_r;
	assign mscratch_q = mscratch_r;
	assign mstatus_mie = mie_r;
	assign mepc_ret_addr = mepc_r;

endmodule

// ==== source/csr_intr_regs.sv ====
`timescale 1ns/1ps

module csr_intr_regs (
	input logic clk,
	input logic resetn,
	input csr_field_pkg::csr_word_u wr_data,
	input csr_addr_pkg::csr_wr_sel_t wr_sel,
	input logic sw_itr_req,
	input logic tmr_itr_req,
	input logic ext_itr_req,
	output csr_field_pkg::csr_word_t mie_q,
	output csr_field_pkg::csr_word_t mip_q,
	output logic mie_msie,
	output logic mie_mtie,
	output logic mie_meie
);

	csr_field_pkg::irq_view_t mie_r; // Reserved bits stay zero from reset
	csr_field_pkg::irq_view_t mip_r;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mie_r <= '0;
		else if (wr_sel.mie)
		begin
			mie_r.me <= wr_data.irq.me;
			mie_r.mt <= wr_data.irq.mt;
			mie_r.ms <= wr_data.irq.ms;
		end
	end

	// Request levels sampled every cycle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mip_r <= '0;
		else
		begin
			mip_r.me <= ext_itr_req;
			mip_r.mt <= tmr_itr_req;
			mip_r.ms <= sw_itr_req;
		end
	end

	assign mie_q = mie_r;
	assign mip_q = mip_r;
	assign mie_msie = mie_r.ms;
	assign mie_mtie = mie_r.mt;
	assign mie_meie = mie_r.me;

endmodule

// ==== source/csr_rw_top.sv ====
`timescale 1ns/1ps

module csr_rw_top (
	input logic clk,
	input logic resetn,
	input logic csr_valid,
	input csr_addr_pkg::csr_addr_t csr_addr,
	input csr_addr_pkg::upd_type_e csr_upd_type,
	input csr_field_pkg::csr_word_t csr_mask_v,
	output csr_field_pkg::csr_word_t csr_dout,
	input logic trap_enter,
	input logic trap_is_intr,
	input logic [csr_field_pkg::ITR_CAUSE_W-1:0] trap_cause,
	input csr_field_pkg::csr_word_t trap_ret_addr,
	input csr_field_pkg::csr_word_t trap_val,
	input logic trap_ret,
	output csr_field_pkg::csr_word_t trap_vec_addr,
	output csr_field_pkg::csr_word_t mepc_ret_addr,
	input logic sw_itr_req,
	input logic tmr_itr_req,
	input logic ext_itr_req,
	output logic mstatus_mie,
	output logic mie_msie,
	output logic mie_mtie,
	output logic mie_meie
);

	csr_field_pkg::csr_word_u wr_data;
	csr_addr_pkg::csr_wr_sel_t wr_sel;
	csr_field_pkg::csr_word_t mstatus_q;
	csr_field_pkg::csr_word_t mtvec_q;
	csr_field_pkg::csr_word_t mepc_q;
	csr_field_pkg::csr_word_t mcause_q;
	csr_field_pkg::csr_word_t mtval_q;
	csr_field_pkg::csr_word_t mscratch_q;
	csr_field_pkg::csr_word_t mie_q;
	csr_field_pkg::csr_word_t mip_q;

	csr_access_port u_access_port (
		.clk(clk),
		.resetn(resetn),
		.csr_valid(csr_valid),
		.csr_addr(csr_addr),
		.csr_upd_type(csr_upd_type),
		.csr_mask_v(csr_mask_v),
		.mstatus_q(mstatus_q),
		.mtvec_q(mtvec_q),
		.mepc_q(mepc_q),
		.mcause_q(mcause_q),
		.mtval_q(mtval_q),
		.mscratch_q(mscratch_q),
		.mie_q(mie_q),
		.mip_q(mip_q),
		.csr_dout(csr_dout),
		.wr_data(wr_data),
		.wr_sel(wr_sel)
	);

	csr_trap_regs u_trap_regs (
		.clk(clk),
		.resetn(resetn),
		.wr_data(wr_data),
		.wr_sel(wr_sel),
		.trap_enter(trap_enter),
		.trap_is_intr(trap_is_intr),
		.trap_cause(trap_cause),
		.trap_ret_addr(trap_ret_addr),
		.trap_val(trap_val),
		.trap_ret(trap_ret),
		.mstatus_q(mstatus_q),
		.mtvec_q(mtvec_q),
		.mepc_q(mepc_q),
		.mcause_q(mcause_q),
		.mtval_q(mtval_q),
		.mscratch_q(mscratch_q),
		.mstatus_mie(mstatus_mie),
		.trap_vec_addr(trap_vec_addr),
		.mepc_ret_addr(mepc_ret_addr)
	);

	csr_intr_regs u_intr_regs (
		.clk(clk),
		.resetn(resetn),
		.wr_data(wr_data),
		.wr_sel(wr_sel),
		.sw_itr_req(sw_itr_req),
		.tmr_itr_req(tmr_itr_req),
		.ext_itr_req(ext_itr_req),
		.mie_q(mie_q),
		.mip_q(mip_q),
		.mie_msie(mie_msie),
		.mie_mtie(mie_mtie),
		.mie_meie(mie_meie)
	);

endmodule

// ==== test/csr_rw_chk.sv ====
`timescale 1ns/1ps

module csr_rw_chk (
	input logic clk,
	input logic resetn,
	input logic csr_valid,
	input csr_addr_pkg::csr_addr_t csr_addr,
	input csr_addr_pkg::upd_type_e csr_upd_type,
	input logic [31:0] csr_mask_v,
	input logic [31:0] csr_dout,
	input logic trap_enter,
	input logic trap_ret,
	input logic mstatus_mie,
	input logic sw_itr_req,
	input logic tmr_itr_req,
	input logic ext_itr_req,
	input logic mie_msie,
	input logic mie_mtie,
	input logic mie_meie
);

	int err_cnt = 0; // Failed assertions so far

	logic [31:0] upd_now; // Word a write in this cycle should leave behind
	logic [2:0] irq_new; // Enable bits of upd_now
	logic [31:0] mip_now; // Request levels in the mip layout
	logic data_reg; // Plain data CSR addressed
	logic mpie_exp;

	always_comb
	begin
		case (csr_upd_type)
			csr_addr_pkg::UPD_LOAD: upd_now = csr_mask_v;
			csr_addr_pkg::UPD_SET: upd_now = csr_dout | csr_mask_v;
			csr_addr_pkg::UPD_CLR: upd_now = csr_dout & ~csr_mask_v;
			default: upd_now = csr_dout;
		endcase
	end

	assign irq_new = {upd_now[11], upd_now[7], upd_now[3]};
	assign mip_now = {20'b0, ext_itr_req, 3'b0, tmr_itr_req, 3'b0, sw_itr_req, 3'b0};
	assign data_reg = (csr_addr == csr_addr_pkg::ADDR_MSCRATCH) ||
		(csr_addr == csr_addr_pkg::ADDR_MTVAL);

	// MPIE as trap entry, trap return and mstatus writes define it
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mpie_exp <= 1'b1;
		else if (trap_enter)
			mpie_exp <= mstatus_mie;
		else if (trap_ret)
			mpie_exp <= 1'b1;
		else if (csr_valid && csr_addr == csr_addr_pkg::ADDR_MSTATUS)
			mpie_exp <= upd_now[7];
	end

	a_rmw_result: assert property (@(posedge clk) disable iff (!resetn)
		csr_valid && data_reg && !trap_enter |=>
		(csr_addr != $past(csr_addr)) || (csr_dout == $past(upd_now)))
	else
	begin
		$error("data CSR does not hold the updated word after a write");
		err_cnt++;
	end

	a_enter_clears_mie: assert property (@(posedge clk) disable iff (!resetn)
		trap_enter |=> !mstatus_mie)
	else
	begin
		$error("mstatus_mie still set after trap entry");
		err_cnt++;
	end

	a_ret_restores_mie: assert property (@(posedge clk) disable iff (!resetn)
		trap_ret && !trap_enter |=> mstatus_mie == $past(mpie_exp))
	else
	begin
		$error("mstatus_mie not restored from MPIE on trap return");
		err_cnt++;
	end

	a_mip_delay: assert property (@(posedge clk) disable iff (!resetn)
		csr_addr == csr_addr_pkg::ADDR_MIP |-> csr_dout == $past(mip_now))
	else
	begin
		$error("mip does not show the previous request levels");
		err_cnt++;
	end

	a_mie_outputs: assert property (@(posedge clk) disable iff (!resetn)
		csr_valid && csr_addr == csr_addr_pkg::ADDR_MIE |=>
		{mie_meie, mie_mtie, mie_msie} == $past(irq_new))
	else
	begin
		$error("enable outputs do not follow the mie write");
		err_cnt++;
	end

endmodule

bind csr_rw_top csr_rw_chk u_chk (
	.clk(clk),
	.resetn(resetn),
	.csr_valid(csr_valid),
	.csr_addr(csr_addr),
	.csr_upd_type(csr_upd_type),
	.csr_mask_v(csr_mask_v),
	.csr_dout(csr_dout),
	.trap_enter(trap_enter),
	.trap_ret(trap_ret),
	.mstatus_mie(mstatus_mie),
	.sw_itr_req(sw_itr_req),
	.tmr_itr_req(tmr_itr_req),
	.ext_itr_req(ext_itr_req),
	.mie_msie(mie_msie),
	.mie_mtie(mie_mtie),
	.mie_meie(mie_meie)
);

// ==== test/csr_rw_tb.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_rw_tb;

	localparam int TIMEOUT_CYCLES = 400; // About twice the ~210 cycles of all tests
	localparam int SEED = 62;

	logic clk;
	logic resetn;
	logic csr_valid;
	csr_addr_pkg::csr_addr_t csr_addr;
	csr_addr_pkg::upd_type_e csr_upd_type;
	logic [31:0] csr_mask_v;
	logic [31:0] csr_dout;
	logic trap_enter;
	logic trap_is_intr;
	logic [csr_field_pkg::ITR_CAUSE_W-1:0] trap_cause;
	logic [31:0] trap_ret_addr;
	logic [31:0] trap_val;
	logic trap_ret;
	logic [31:0] trap_vec_addr;
	logic [31:0] mepc_ret_addr;
	logic sw_itr_req;
	logic tmr_itr_req;
	logic ext_itr_req;
	logic mstatus_mie;
	logic mie_msie;
	logic mie_mtie;
	logic mie_meie;

	int cycles = 0;
	int errors = 0; // Mismatches in the running test
	int chk_base = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;

	csr_rw_top u_dut (
		.clk(clk),
		.resetn(resetn),
		.csr_valid(csr_valid),
		.csr_addr(csr_addr),
		.csr_upd_type(csr_upd_type),
		.csr_mask_v(csr_mask_v),
		.csr_dout(csr_dout),
		.trap_enter(trap_enter),
		.trap_is_intr(trap_is_intr),
		.trap_cause(trap_cause),
		.trap_ret_addr(trap_ret_addr),
		.trap_val(trap_val),
		.trap_ret(trap_ret),
		.trap_vec_addr(trap_vec_addr),
		.mepc_ret_addr(mepc_ret_addr),
		.sw_itr_req(sw_itr_req),
		.tmr_itr_req(tmr_itr_req),
		.ext_itr_req(ext_itr_req),
		.mstatus_mie(mstatus_mie),
		.mie_msie(mie_msie),
		.mie_mtie(mie_mtie),
		.mie_meie(mie_meie)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic read_csr(input csr_addr_pkg::csr_addr_t addr, output logic [31:0] data);
		csr_valid = 1'b0;
		csr_addr = addr;
		#2;
		data = csr_dout; // Mid-cycle, combinational path settled
		next_cycle();
	endtask

	task automatic write_csr(input csr_addr_pkg::csr_addr_t addr,
		input csr_addr_pkg::upd_type_e kind, input logic [31:0] mask, output logic [31:0] old);
		csr_valid = 1'b1;
		csr_addr = addr;
		csr_upd_type = kind;
		csr_mask_v = mask;
		#2;
		old = csr_dout;
		next_cycle();
		csr_valid = 1'b0;
	endtask

	task automatic expect_read(input string name, input csr_addr_pkg::csr_addr_t addr,
		input logic [31:0] exp);
		logic [31:0] data;
		read_csr(addr, data);
		check_value(name, data, exp);
	endtask

	task automatic start_test;
		errors = 0;
		chk_base = u_dut.u_chk.err_cnt;
	endtask

	task automatic end_test(input string name);
		int chk_errs;
		chk_errs = u_dut.u_chk.err_cnt - chk_base;
		if (errors == 0 && chk_errs == 0)
		begin
			$display("%s test passed", name);
			pass_cnt++;
		end
		else
		begin
			$display("%s test done, %0d mismatches, %0d assertion failures", name, errors,
				chk_errs);
			fail_cnt++;
		end
	endtask

	// Load, set or clear as the CSR instructions define them
	function automatic logic [31:0] apply_update(input logic [31:0] old,
		input logic [31:0] mask, input csr_addr_pkg::upd_type_e kind);
		case (kind)
			csr_addr_pkg::UPD_SET: return old | mask;
			csr_addr_pkg::UPD_CLR: return old & ~mask;
			default: return mask;
		endcase
	endfunction

	function automatic csr_addr_pkg::upd_type_e random_kind;
		case ($urandom % 3)
			0: return csr_addr_pkg::UPD_LOAD;
			1: return csr_addr_pkg::UPD_SET;
			default: return csr_addr_pkg::UPD_CLR;
		endcase
	endfunction

	initial
	begin
		logic [31:0] old;
		logic [31:0] mask;
		logic [31:0] base;
		logic [31:0] ret_pc;
		logic [31:0] tval;
		logic [31:0] model [2]; // mscratch, mtval
		logic [csr_field_pkg::ITR_CAUSE_W-1:0] cause;
		logic [2:0] req;
		logic [2:0] prev_req;
		csr_addr_pkg::upd_type_e kind;
		csr_addr_pkg::csr_addr_t addr;
		bit pick;
		string name;
		void'($urandom(SEED));
		resetn = 1'b0;
		csr_valid = 1'b0;
		csr_addr = '0;
		csr_upd_type = csr_addr_pkg::UPD_LOAD;
		csr_mask_v = '0;
		trap_enter = 1'b0;
		trap_is_intr = 1'b0;
		trap_cause = '0;
		trap_ret_addr = '0;
		trap_val = '0;
		trap_ret = 1'b0;
		sw_itr_req = 1'b0;
		tmr_itr_req = 1'b0;
		ext_itr_req = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;

		start_test();
		check_value("enables", {28'b0, mstatus_mie, mie_meie, mie_mtie, mie_msie}, 32'h0);
		expect_read("mstatus", csr_addr_pkg::ADDR_MSTATUS, 32'h0000_1880); // MPP 3, MPIE 1
		expect_read("mcause", csr_addr_pkg::ADDR_MCAUSE, `CSR_MCAUSE_INIT);
		expect_read("mtvec", csr_addr_pkg::ADDR_MTVEC, {`CSR_MTVEC_BASE_INIT, 2'b00});
		expect_read("misa", csr_addr_pkg::ADDR_MISA, `CSR_MISA_VAL);
		expect_read("mvendorid", csr_addr_pkg::ADDR_MVENDORID, `CSR_MVENDORID_VAL);
		expect_read("marchid", csr_addr_pkg::ADDR_MARCHID, `CSR_MARCHID_VAL);
		expect_read("mimpid", csr_addr_pkg::ADDR_MIMPID, `CSR_MIMPID_VAL);
		expect_read("mhartid", csr_addr_pkg::ADDR_MHARTID, `CSR_MHARTID_VAL);
		expect_read("mie", csr_addr_pkg::ADDR_MIE, 32'h0);
		expect_read("unmapped", 12'h7C0, 32'h0);
		end_test("reset");

		start_test();
		model[0] = $urandom;
		model[1] = $urandom;
		write_csr(csr_addr_pkg::ADDR_MSCRATCH, csr_addr_pkg::UPD_LOAD, model[0], old);
		write_csr(csr_addr_pkg::ADDR_MTVAL, csr_addr_pkg::UPD_LOAD, model[1], old);
		repeat (80)
		begin
			pick = 1'($urandom);
			kind = random_kind();
			mask = $urandom;
			if (pick)
			begin
				addr = csr_addr_pkg::ADDR_MTVAL;
				name = "mtval";
			end
			else
			begin
				addr = csr_addr_pkg::ADDR_MSCRATCH;
				name = "mscratch";
			end
			write_csr(addr, kind, mask, old);
			check_value({name, " old"}, old, model[pick]); // Write cycle shows old value
			model[pick] = apply_update(model[pick], mask, kind);
			expect_read(name, addr, model[pick]);
		end
		end_test("atomic");

		start_test();
		write_csr(csr_addr_pkg::ADDR_MSTATUS, csr_addr_pkg::UPD_LOAD, 32'h8, old); // MIE on, MPIE off
		check_value("mstatus_mie", {31'b0, mstatus_mie}, 32'h1);
		expect_read("mstatus", csr_addr_pkg::ADDR_MSTATUS, 32'h0000_1808);
		ret_pc = $urandom;
		tval = $urandom;
		cause = csr_field_pkg::ITR_CAUSE_W'($urandom);
		trap_enter = 1'b1;
		trap_is_intr = 1'b0;
		trap_cause = cause;
		trap_ret_addr = ret_pc;
		trap_val = tval;
		next_cycle();
		trap_enter = 1'b0;
		check_value("mstatus_mie", {31'b0, mstatus_mie}, 32'h0);
		check_value("mepc_ret_addr", mepc_ret_addr, ret_pc);
		expect_read("mstatus", csr_addr_pkg::ADDR_MSTATUS, 32'h0000_1880); // MPIE took MIE
		expect_read("mepc", csr_addr_pkg::ADDR_MEPC, ret_pc);
		expect_read("mcause", csr_addr_pkg::ADDR_MCAUSE, 32'(cause));
		expect_read("mtval", csr_addr_pkg::ADDR_MTVAL, tval);
		trap_ret = 1'b1;
		next_cycle();
		trap_ret = 1'b0;
		check_value("mstatus_mie", {31'b0, mstatus_mie}, 32'h1);
		expect_read("mstatus", csr_addr_pkg::ADDR_MSTATUS, 32'h0000_1888);
		write_csr(csr_addr_pkg::ADDR_MSTATUS, csr_addr_pkg::UPD_LOAD, 32'h0, old); // MIE and MPIE off
		trap_ret = 1'b1;
		next_cycle();
		trap_ret = 1'b0;
		check_value("mstatus_mie", {31'b0, mstatus_mie}, 32'h0);
		expect_read("mstatus", csr_addr_pkg::ADDR_MSTATUS, 32'h0000_1880);
		end_test("trap");

		start_test();
		base = $urandom & 32'hFFFF_FFFC;
		cause = csr_field_pkg::ITR_CAUSE_W'($urandom);
		trap_is_intr = 1'b1;
		trap_cause = cause;
		write_csr(csr_addr_pkg::ADDR_MTVEC, csr_addr_pkg::UPD_LOAD, base, old); // Direct
		#2;
		check_value("trap_vec_addr", trap_vec_addr, base);
		next_cycle();
		write_csr(csr_addr_pkg::ADDR_MTVEC, csr_addr_pkg::UPD_LOAD, base | 32'h1, old);
		#2;
		if (`CSR_VECTORED_EN)
			check_value("trap_vec_addr", trap_vec_addr, base + (32'(cause) << 2));
		else
			check_value("trap_vec_addr", trap_vec_addr, base);
		trap_is_intr = 1'b0; // Exceptions always use the base
		#1;
		check_value("trap_vec_addr", trap_vec_addr, base);
		next_cycle();
		end_test("vector");

		start_test();
		write_csr(csr_addr_pkg::ADDR_MIE, csr_addr_pkg::UPD_LOAD, 32'h0000_0888, old);
		check_value("mie enables", {29'b0, mie_meie, mie_mtie, mie_msie}, 32'h7);
		write_csr(csr_addr_pkg::ADDR_MIE, csr_addr_pkg::UPD_CLR, 32'h0000_0808, old);
		check_value("mie enables", {29'b0, mie_meie, mie_mtie, mie_msie}, 32'h2);
		write_csr(csr_addr_pkg::ADDR_MIE, csr_addr_pkg::UPD_SET, 32'h0000_0800, old);
		check_value("mie enables", {29'b0, mie_meie, mie_mtie, mie_msie}, 32'h6);
		write_csr(csr_addr_pkg::ADDR_MIE, csr_addr_pkg::UPD_LOAD, 32'h0000_0008, old);
		check_value("mie enables", {29'b0, mie_meie, mie_mtie, mie_msie}, 32'h1);
		prev_req = 3'b000; // Levels held low since reset
		repeat (16)
		begin
			req = 3'($urandom);
			{ext_itr_req, tmr_itr_req, sw_itr_req} = req;
			csr_addr = csr_addr_pkg::ADDR_MIP;
			#2;
			check_value("mip", csr_dout,
				{20'b0, prev_req[2], 3'b0, prev_req[1], 3'b0, prev_req[0], 3'b0});
			prev_req = req;
			next_cycle();
		end
		{ext_itr_req, tmr_itr_req, sw_itr_req} = 3'b000;
		end_test("interrupt");

		start_test();
		ret_pc = $urandom;
		trap_enter = 1'b1; // Same cycle as the software write
		trap_ret_addr = ret_pc;
		write_csr(csr_addr_pkg::ADDR_MEPC, csr_addr_pkg::UPD_LOAD, ~ret_pc, old);
		trap_enter = 1'b0;
		expect_read("mepc", csr_addr_pkg::ADDR_MEPC, ret_pc);
		end_test("priority");

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+source
source/csr_addr_pkg.sv
source/csr_field_pkg.sv
source/csr_access_port.sv
source/csr_trap_regs.sv
source/csr_intr_regs.sv
source/csr_rw_top.sv
test/csr_rw_chk.sv
test/csr_rw_tb.sv

// ==== Makefile ====
TOP := csr_rw_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f source/*.sv source/*.svh test/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
